// File: project.f
+incdir+hw
hw/mips_dec_pkg.sv
hw/op_decode.sv
hw/compare_eval.sv
hw/ctrl_merge.sv
hw/decoder_mips.sv
bench/tb_clock_gen.sv
bench/tb_decoder_mips.sv

// File: bench/tb_decoder_mips.sv
// MIPS decoder testbench
`include "mips_dec_params.svh"

module tb_decoder_mips;
	timeunit 1ns;
	timeprecision 100ps;

	// Reset, mem, imm x2, branch x8, funct sweep, jumps, random
	localparam int N_STIM = 10 + 2 + 16 + 32 + 64 + 6 + 400;
	localparam int TIMEOUT_CYCLES = N_STIM + 50;

	// Expected register contents after one edge
	typedef struct packed {
		logic [`MIPS_CTRL_W-1:0] ctrol;
		mips_dec_pkg::alu_op_t   alu_op;
		logic [`MIPS_WORD_W-1:0] rt;
		logic                    slt_mux;
		logic                    zero_ext;
	} dec_result_t;

	logic                      clk;
	logic                      rst_n;
	logic [`MIPS_OPCODE_W-1:0] opcode;
	logic [`MIPS_FUNCT_W-1:0]  funct;
	logic                      equalrsrt;
	logic                      rsmaior;
	logic                      rsmrt;
	logic [`MIPS_CTRL_W-1:0]   ctrol;
	mips_dec_pkg::alu_op_t     outsaida;
	logic [`MIPS_WORD_W-1:0]   rt;
	logic                      slt_mux;
	logic                      zero_ext;

	int          err_ctrl = 0;
	int          err_alu = 0;
	int          err_word = 0;
	int          err_bit = 0;
	int          cycle_cnt = 0;
	logic [31:0] rng_state = 32'd55027;
	dec_result_t pending = '0;

	tb_clock_gen u_clock_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	decoder_mips UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.opcode    (opcode),
		.funct     (funct),
		.equalrsrt (equalrsrt),
		.rsmaior   (rsmaior),
		.rsmrt     (rsmrt),
		.ctrol     (ctrol),
		.outsaida  (outsaida),
		.rt        (rt),
		.slt_mux   (slt_mux),
		.zero_ext  (zero_ext)
	);

	// ----------------------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------------------
	function automatic logic [31:0] xorshift_next(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// SPECIAL funct table with shifts when bit 5 is clear
	function automatic mips_dec_pkg::alu_op_t alu_op_for_funct(input logic [5:0] fn);
		mips_dec_pkg::alu_op_t op;
		casez (fn)
			6'b0???00: op = mips_dec_pkg::L_SH;
			6'b0???10: op = mips_dec_pkg::R_SH;
			// SRA and odd shifts
			6'b0?????: op = mips_dec_pkg::ADD;
			6'b1??00?: op = mips_dec_pkg::ADD;
			6'b1??01?: op = mips_dec_pkg::SUB;
			6'b1??100: op = mips_dec_pkg::AND;
			6'b1??101: op = mips_dec_pkg::OR;
			6'b1??110: op = mips_dec_pkg::XOR;
			default:   op = mips_dec_pkg::NOR;
		endcase
		return op;
	endfunction

	// Control word order is jorf ctrl addorn rori instype reoral ref_w_ena d_mem_wena
	function automatic dec_result_t ref_decode(input logic [5:0] op, input logic [5:0] fn,
	                                           input logic eq, input logic mai,
	                                           input logic mrt);
		dec_result_t r;
		logic        taken;
		r = '0;
		taken = 1'b0;
		casez (op)
			// SW
			6'b1?1???: r.ctrol = 8'b0000_0001;
			// LW
			6'b1?0???: r.ctrol = 8'b0000_1010;
			// Immediates
			6'b0?1???: begin
				r.ctrol = 8'b0000_1110;
				case (op[2:0])
					3'b100: begin
						r.alu_op = mips_dec_pkg::AND;
						r.zero_ext = 1'b1;
					end
					3'b101: begin
						r.alu_op = mips_dec_pkg::OR;
						r.zero_ext = 1'b1;
					end
					3'b110: begin
						r.alu_op = mips_dec_pkg::XOR;
						r.zero_ext = 1'b1;
					end
					3'b010, 3'b011: r.slt_mux = 1'b1;
					default: r.alu_op = mips_dec_pkg::ADD;
				endcase
			end
			// Branches
			6'b0?01??: begin
				case (mips_dec_pkg::branch_cond_t'(op[1:0]))
					mips_dec_pkg::BEQ:  taken = eq;
					mips_dec_pkg::BNE:  taken = !eq;
					mips_dec_pkg::BLEZ: taken = eq || mrt;
					default:            taken = !eq && !mrt;
				endcase
				r.ctrol = {taken, 7'b001_1100};
				r.alu_op = mips_dec_pkg::COMP;
			end
			6'b0?0000: begin
				r.ctrol = 8'b0011_0110;
				r.alu_op = alu_op_for_funct(fn);
			end
			// J, JAL and every leftover opcode
			default: r.ctrol = 8'b1100_0000;
		endcase
		r.rt = r.slt_mux ? {{(`MIPS_WORD_W-1){1'b0}}, !mai} : '0;
		return r;
	endfunction

	// ----------------------------------------------------------------------
	// Compare tasks
	// ----------------------------------------------------------------------
	task automatic check_ctrl(input logic [`MIPS_CTRL_W-1:0] exp,
	                          input logic [`MIPS_CTRL_W-1:0] act);
		if (act !== exp) begin
			err_ctrl++;
			$display("ERROR ctrol: expected 0x%02h, got 0x%02h at %0t", exp, act, $time);
		end
	endtask

	task automatic check_alu_op(input mips_dec_pkg::alu_op_t exp,
	                            input mips_dec_pkg::alu_op_t act);
		if (act !== exp) begin
			err_alu++;
			$display("ERROR outsaida: expected 0x%01h, got 0x%01h at %0t", exp, act, $time);
		end
	endtask

	task automatic check_word(input string name, input logic [`MIPS_WORD_W-1:0] exp,
	                          input logic [`MIPS_WORD_W-1:0] act);
		if (act !== exp) begin
			err_word++;
			$display("ERROR %s: expected 0x%08h, got 0x%08h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			err_bit++;
			$display("ERROR %s: expected 0x%01h, got 0x%01h at %0t", name, exp, act, $time);
		end
	endtask

	// One instruction per cycle with flags as {equalrsrt, rsmaior, rsmrt}
	task automatic apply_instr(input logic [5:0] op, input logic [5:0] fn,
	                           input logic [2:0] flags);
		@(posedge clk);
		#2;
		opcode = op;
		funct = fn;
		{equalrsrt, rsmaior, rsmrt} = flags;
	endtask

	task automatic apply_random_flags(input logic [5:0] op, input logic [5:0] fn);
		rng_state = xorshift_next(rng_state);
		apply_instr(op, fn, rng_state[2:0]);
	endtask

	// ----------------------------------------------------------------------
	// Checking at the falling edge
	// ----------------------------------------------------------------------
	// Outputs now hold what was presented one falling edge ago
	always @(negedge clk) begin
		check_ctrl(pending.ctrol, ctrol);
		check_alu_op(pending.alu_op, outsaida);
		check_word("rt", pending.rt, rt);
		check_bit("slt_mux", pending.slt_mux, slt_mux);
		check_bit("zero_ext", pending.zero_ext, zero_ext);
		// Register stays cleared while in reset
		if (rst_n)
			pending = ref_decode(opcode, funct, equalrsrt, rsmaior, rsmrt);
		else
			pending = '0;
	end

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	initial begin : watchdog
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	// ----------------------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------------------
	initial begin : stimulus
		int total;
		opcode = '0;
		funct = '0;
		equalrsrt = 1'b0;
		rsmaior = 1'b0;
		rsmrt = 1'b0;
		wait (rst_n === 1'b1);

		// LW and SW
		apply_random_flags(6'b100011, 6'h00);
		apply_random_flags(6'b101011, 6'h00);

		// Immediates under both rsmaior values for the SLT pair
		for (int m = 0; m < 2; m++)
			for (int k = 0; k < 8; k++)
				apply_instr({3'b001, 3'(k)}, 6'h00, {1'b0, 1'(m), 1'b0});

		// Branches under every flag combination
		for (int k = 0; k < 4; k++)
			for (int f = 0; f < 8; f++)
				apply_instr({4'b0001, 2'(k)}, 6'h00, 3'(f));

		// Full funct sweep
		for (int k = 0; k < 64; k++)
			apply_random_flags(6'b000000, 6'(k));

		// J, JAL and fall-through opcodes
		apply_random_flags(6'b000010, 6'h00);
		apply_random_flags(6'b000011, 6'h00);
		apply_random_flags(6'b000001, 6'h15);
		apply_random_flags(6'b010001, 6'h00);
		apply_random_flags(6'b010010, 6'h2a);
		apply_random_flags(6'b010011, 6'h00);

		// Back-to-back random
		for (int k = 0; k < 400; k++) begin
			rng_state = xorshift_next(rng_state);
			apply_instr(rng_state[5:0], rng_state[11:6], rng_state[14:12]);
		end

		// Let the last instruction reach the outputs
		repeat (2) @(posedge clk);
		total = err_ctrl + err_alu + err_word + err_bit;
		$display("Errors: ctrol=%0d outsaida=%0d rt=%0d bits=%0d total=%0d",
		         err_ctrl, err_alu, err_word, err_bit, total);
		if (total == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: bench/tb_clock_gen.sv
// Testbench clock and reset
module tb_clock_gen (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	// 20 ns period
	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 10;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// Released just after a rising edge, like the other inputs
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 rst_n = 1'b1;
	end

endmodule

// File: hw/decoder_mips.sv
// MIPS instruction decoder top
`include "mips_dec_params.svh"

module decoder_mips (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [`MIPS_OPCODE_W-1:0] opcode,
	input  logic [`MIPS_FUNCT_W-1:0]  funct,
	input  logic                      equalrsrt,
	input  logic                      rsmaior,
	input  logic                      rsmrt,
	output logic [`MIPS_CTRL_W-1:0]   ctrol,
	output mips_dec_pkg::alu_op_t     outsaida,
	output logic [`MIPS_WORD_W-1:0]   rt,
	output logic                      slt_mux,
	output logic                      zero_ext
);

	// Decode stage results
	mips_dec_pkg::instr_class_t instr_class;
	mips_dec_pkg::alu_op_t      alu_op;
	logic rori;
	logic instype;
	logic reoral;
	logic ref_w_ena;
	logic d_mem_wena;
	logic dec_slt_mux;
	logic dec_zero_ext;
	// Comparator results
	logic cond_met;
	logic slt_bit;

	// ----------------------------------------------------------------------
	// Decode stage
	// ----------------------------------------------------------------------
	op_decode u_op_decode (
		.clk         (clk),
		.opcode      (opcode),
		.funct       (funct),
		.instr_class (instr_class),
		.alu_op      (alu_op),
		.rori        (rori),
		.instype     (instype),
		.reoral      (reoral),
		.ref_w_ena   (ref_w_ena),
		.d_mem_wena  (d_mem_wena),
		.slt_mux     (dec_slt_mux),
		.zero_ext    (dec_zero_ext)
	);

	compare_eval u_compare_eval (
		.opcode    (opcode),
		.equalrsrt (equalrsrt),
		.rsmaior   (rsmaior),
		.rsmrt     (rsmrt),
		.cond_met  (cond_met),
		.slt_bit   (slt_bit)
	);

	// Stage register toward execute
	ctrl_merge u_ctrl_merge (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_class (instr_class),
		.alu_op      (alu_op),
		.rori        (rori),
		.instype     (instype),
		.reoral      (reoral),
		.ref_w_ena   (ref_w_ena),
		.d_mem_wena  (d_mem_wena),
		.slt_mux_in  (dec_slt_mux),
		.zero_ext_in (dec_zero_ext),
		.cond_met    (cond_met),
		.slt_bit     (slt_bit),
		.ctrol       (ctrol),
		.outsaida    (outsaida),
		.rt          (rt),
		.slt_mux     (slt_mux),
		.zero_ext    (zero_ext)
	);

endmodule

// File: hw/ctrl_merge.sv
// Control merge and decode register
`include "mips_dec_params.svh"

module ctrl_merge (
	input  logic                            clk,
	input  logic                            rst_n,
	input  mips_dec_pkg::instr_class_t      instr_class,
	input  mips_dec_pkg::alu_op_t           alu_op,
	input  logic                            rori,
	input  logic                            instype,
	input  logic                            reoral,
	input  logic                            ref_w_ena,
	input  logic                            d_mem_wena,
	input  logic                            slt_mux_in,
	input  logic                            zero_ext_in,
	input  logic                            cond_met,
	input  logic                            slt_bit,
	output logic [`MIPS_CTRL_W-1:0]         ctrol,
	output mips_dec_pkg::alu_op_t           outsaida,
	output logic [`MIPS_WORD_W-1:0]         rt,
	output logic                            slt_mux,
	output logic                            zero_ext
);

	logic                    jorf;
	logic                    ctrl;
	logic                    addorn;
	logic [`MIPS_CTRL_W-1:0] ctrol_d;
	logic [`MIPS_WORD_W-1:0] rt_d;

	// ----------------------------------------------------------------------
	// PC path
	// ----------------------------------------------------------------------
	// Branch outcome only counts for the branch class
	assign jorf   = (instr_class == mips_dec_pkg::CLS_JUMP) ||
	                ((instr_class == mips_dec_pkg::CLS_BRANCH) && cond_met);
	assign ctrl   = (instr_class == mips_dec_pkg::CLS_JUMP);
	assign addorn = (instr_class == mips_dec_pkg::CLS_SPECIAL);

	// Control word, jorf in the MSB
	assign ctrol_d = {jorf, ctrl, addorn, rori, instype, reoral, ref_w_ena, d_mem_wena};

	// SLT result zero-extended to a word
	assign rt_d = slt_mux_in ? {{(`MIPS_WORD_W-1){1'b0}}, slt_bit} : '0;

	// ----------------------------------------------------------------------
	// Decode to execute register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrol    <= '0;
			outsaida <= mips_dec_pkg::ADD;
			rt       <= '0;
			slt_mux  <= 1'b0;
			zero_ext <= 1'b0;
		end else begin
			ctrol    <= ctrol_d;
			outsaida <= alu_op;
			rt       <= rt_d;
			slt_mux  <= slt_mux_in;
			zero_ext <= zero_ext_in;
		end
	end

	// Jump select only together with a taken PC change
	a_ctrl_jorf: assert property (@(posedge clk) disable iff (!rst_n)
		ctrol[`MIPS_CTRL_CTRL] |-> ctrol[`MIPS_CTRL_JORF]);

endmodule

// File: hw/compare_eval.sv
// Branch condition evaluation
`include "mips_dec_params.svh"

module compare_eval (
	input  logic [`MIPS_OPCODE_W-1:0] opcode,
	input  logic                      equalrsrt,
	input  logic                      rsmaior,
	input  logic                      rsmrt,
	output logic                      cond_met,
	output logic                      slt_bit
);

	// ----------------------------------------------------------------------
	// Condition select
	// ----------------------------------------------------------------------
	mips_dec_pkg::branch_cond_t cond;

	// Low opcode bits pick the condition
	assign cond = mips_dec_pkg::branch_cond_t'(opcode[1:0]);

	// Evaluated for every opcode, gated later by class
	always_comb begin
		case (cond)
			mips_dec_pkg::BEQ:
				cond_met = equalrsrt;
			mips_dec_pkg::BNE:
				cond_met = !equalrsrt;
			mips_dec_pkg::BLEZ:
				// Equal or rs below
				cond_met = equalrsrt || rsmrt;
			default:
				// BGTZ, strictly above
				cond_met = !equalrsrt && !rsmrt;
		endcase
	end

	// ----------------------------------------------------------------------
	// Set-less-than
	// ----------------------------------------------------------------------
	// rs not greater means set
	assign slt_bit = !rsmaior;

endmodule

// File: hw/op_decode.sv
// Opcode and funct decode
`include "mips_dec_params.svh"

module op_decode (
	input  logic                            clk,
	input  logic [`MIPS_OPCODE_W-1:0]       opcode,
	input  logic [`MIPS_FUNCT_W-1:0]        funct,
	output mips_dec_pkg::instr_class_t      instr_class,
	output mips_dec_pkg::alu_op_t           alu_op,
	output logic                            rori,
	output logic                            instype,
	output logic                            reoral,
	output logic                            ref_w_ena,
	output logic                            d_mem_wena,
	output logic                            slt_mux,
	output logic                            zero_ext
);

	// ----------------------------------------------------------------------
	// Class selection
	// ----------------------------------------------------------------------
	// Priority follows the bit tests, first hit wins
	always_comb begin
		if (opcode[`MIPS_OP_MEM_BIT])
			instr_class = mips_dec_pkg::CLS_MEM;
		else if (opcode[`MIPS_OP_IMM_BIT])
			instr_class = mips_dec_pkg::CLS_IMM;
		else if (opcode[`MIPS_OP_BR_BIT])
			instr_class = mips_dec_pkg::CLS_BRANCH;
		else if (opcode[1:0] == 2'b00)
			instr_class = mips_dec_pkg::CLS_SPECIAL;
		else
			// J, JAL and anything left over
			instr_class = mips_dec_pkg::CLS_JUMP;
	end

	// ----------------------------------------------------------------------
	// Datapath controls per class
	// ----------------------------------------------------------------------
	always_comb begin
		// Everything off unless the class says otherwise
		alu_op     = mips_dec_pkg::ADD;
		rori       = 1'b0;
		instype    = 1'b0;
		reoral     = 1'b0;
		ref_w_ena  = 1'b0;
		d_mem_wena = 1'b0;
		slt_mux    = 1'b0;
		zero_ext   = 1'b0;

		case (instr_class)
			mips_dec_pkg::CLS_MEM: begin
				// Address always rs + imm
				if (opcode[`MIPS_OP_IMM_BIT]) begin
					// SW
					d_mem_wena = 1'b1;
				end else begin
					// LW, result into rt
					instype   = 1'b1;
					ref_w_ena = 1'b1;
				end
			end

			mips_dec_pkg::CLS_IMM: begin
				// Common to all immediates, rt destination and ALU writeback
				instype   = 1'b1;
				reoral    = 1'b1;
				ref_w_ena = 1'b1;
				case (mips_dec_pkg::imm_op_t'(opcode[2:0]))
					mips_dec_pkg::ANDI: begin
						alu_op   = mips_dec_pkg::AND;
						zero_ext = 1'b1;
					end
					mips_dec_pkg::ORI: begin
						alu_op   = mips_dec_pkg::OR;
						zero_ext = 1'b1;
					end
					mips_dec_pkg::XORI: begin
						alu_op   = mips_dec_pkg::XOR;
						zero_ext = 1'b1;
					end
					// Result comes from the comparator, not the ALU
					mips_dec_pkg::SLTI,
					mips_dec_pkg::SLTIU:
						slt_mux = 1'b1;
					// ADDI, ADDIU and LUI all add
					default:
						alu_op = mips_dec_pkg::ADD;
				endcase
			end

			mips_dec_pkg::CLS_BRANCH: begin
				// Compare rs against rt
				rori    = 1'b1;
				alu_op  = mips_dec_pkg::COMP;
				instype = 1'b1;
				reoral  = 1'b1;
			end

			mips_dec_pkg::CLS_SPECIAL: begin
				// R-type, rd destination
				rori      = 1'b1;
				reoral    = 1'b1;
				ref_w_ena = 1'b1;
				if (!funct[`MIPS_FN_ALU_BIT]) begin
					// Shift sub-decode
					case (funct[1:0])
						2'b00:   alu_op = mips_dec_pkg::L_SH;
						2'b10:   alu_op = mips_dec_pkg::R_SH;
						// SRA and the rest fall back to ADD
						default: alu_op = mips_dec_pkg::ADD;
					endcase
				end else begin
					case (funct[2:0])
						3'd0, 3'd1: alu_op = mips_dec_pkg::ADD;
						3'd2, 3'd3: alu_op = mips_dec_pkg::SUB;
						3'd4:       alu_op = mips_dec_pkg::AND;
						3'd5:       alu_op = mips_dec_pkg::OR;
						3'd6:       alu_op = mips_dec_pkg::XOR;
						default:    alu_op = mips_dec_pkg::NOR;
					endcase
				end
			end

			// Jumps leave the datapath idle
			default: alu_op = mips_dec_pkg::ADD;
		endcase
	end

	// Register file and data memory never written by the same instruction
	a_wr_excl: assert property (@(posedge clk)
		!(ref_w_ena === 1'b1 && d_mem_wena === 1'b1));

endmodule

// File: hw/mips_dec_pkg.sv
// MIPS decoder types
`include "mips_dec_params.svh"

package mips_dec_pkg;

	// ----------------------------------------------------------------------
	// ALU operation, encoded as the ALU expects it
	// ----------------------------------------------------------------------
	typedef enum logic [`MIPS_ALU_OP_W-1:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		AND  = 4'd2,
		OR   = 4'd3,
		XOR  = 4'd4,
		L_SH = 4'd5,
		R_SH = 4'd6,
		NOR  = 4'd8,
		COMP = 4'd11
	} alu_op_t;

	// Instruction classes, in decode priority order
	typedef enum logic [2:0] {
		CLS_MEM,
		CLS_IMM,
		CLS_BRANCH,
		CLS_SPECIAL,
		CLS_JUMP
	} instr_class_t;

	// Immediate sub-opcode, opcode bits 2..0
	typedef enum logic [2:0] {
		ADDI  = 3'b000,
		ADDIU = 3'b001,
		SLTI  = 3'b010,
		SLTIU = 3'b011,
		ANDI  = 3'b100,
		ORI   = 3'b101,
		XORI  = 3'b110,
		LUI   = 3'b111
	} imm_op_t;

	// Branch condition, opcode bits 1..0
	typedef enum logic [1:0] {
		BEQ  = 2'b00,
		BNE  = 2'b01,
		BLEZ = 2'b10,
		BGTZ = 2'b11
	} branch_cond_t;

endpackage

// File: hw/mips_dec_params.svh
// MIPS decoder parameters
`ifndef MIPS_DEC_PARAMS_SVH
`define MIPS_DEC_PARAMS_SVH

// ----------------------------------------------------------------------
// Field widths
// ----------------------------------------------------------------------
`define MIPS_OPCODE_W 6
`define MIPS_FUNCT_W 6
`define MIPS_ALU_OP_W 4
`define MIPS_CTRL_W 8
`define MIPS_WORD_W 32

// ----------------------------------------------------------------------
// Opcode bit positions used for classification
// ----------------------------------------------------------------------
// Load or store group
`define MIPS_OP_MEM_BIT 5
// Store inside the memory group, immediate group otherwise
`define MIPS_OP_IMM_BIT 3
// Branch group
`define MIPS_OP_BR_BIT 2

// Funct bit splitting shifts from the ALU functions
`define MIPS_FN_ALU_BIT 5

// PC-path bits in the control word
`define MIPS_CTRL_JORF 7
`define MIPS_CTRL_CTRL 6

`endif
